/* verification/periph_input.txt */
# columns: test name, operation, then three hex values a b c (unused ones are 0)
# wr addr data be | rd addr expected | rdm addr (model) | fill addr count | kb byte
# part nbits byte | idle cycles | pulse source(0 timer, 1 uart) cycles | irqchk level
sram_ends   wr     02000000 11223344 f
sram_ends   wr     020007fc a5a5a5a5 f
sram_ends   rd     02000000 11223344 0
sram_ends   rd     020007fc a5a5a5a5 0
sram_be     wr     02000000 ffffffff 5
sram_be     rd     02000000 11ff33ff 0
sram_be     wr     020007fc 00000000 a
sram_be     rd     020007fc 00a500a5 0
sram_be     wr     02000000 deadbeef 8
sram_be     rd     02000000 deff33ff 0
sram_fill   fill   02000100 8 0
sram_fill   rdm    02000100 0 0
sram_fill   rdm    02000104 0 0
sram_fill   rdm    0200011c 0 0
sram_fill   wr     02000108 0000beef 3
sram_fill   wr     02000110 12000000 8
sram_fill   rdm    02000108 0 0
sram_fill   rdm    02000110 0 0
sram_fill   rdm    020007fc 0 0
irq_src     pulse  0 2 0
irq_src     irqchk 1 0 0
irq_src     rdm    02020000 0 0
irq_src     pulse  1 3 0
irq_src     rd     02020000 3 0
irq_clear   wr     02020000 1 f
irq_clear   rd     02020000 2 0
irq_clear   irqchk 1 0 0
unmapped    rd     03000000 0 0
unmapped    wr     03000000 ffffffff f
unmapped    rd     02000000 deff33ff 0
unmapped    rdm    02020000 0 0
irq_clear   wr     02020000 2 f
irq_clear   irqchk 0 0 0
kb_frame    kb     1c 0 0
kb_frame    irqchk 1 0 0
kb_frame    rd     02070000 438 0
kb_frame    rdm    02070000 0 0
kb_frame    rd     02020000 4 0
kb_frame    wr     02020000 4 f
kb_frame    irqchk 0 0 0
kb_restart  part   4 f3 0
kb_restart  idle   12c 0 0
kb_restart  kb     a7 0 0
kb_restart  rdm    02070000 0 0
kb_restart  rdm    02070000 0 0
kb_restart  wr     02020000 7 f
kb_restart  irqchk 0 0 0

/* list.f */
rtl/periph_pkg.sv
rtl/sram_bank.sv
rtl/ps2_keyboard_rx.sv
rtl/irq_controller.sv
rtl/bus_readback.sv
rtl/periph_top.sv
verification/periph_top_sva.sv
verification/tb_periph_top.sv

/* verification/tb_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top
  import periph_pkg::*;
();

  localparam int SRAM_WORDS = 512;
  localparam int IDLE_LIMIT = 200;
  localparam int KB_HALF    = 20;   // key_clk half period in clk cycles
  localparam int MAX_WAITS  = 8;

  logic     clk = 1'b0;
  logic     reset_n;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     key_clk;
  logic     key_data;
  logic     timer_irq;
  logic     uart_irq;
  logic     irq;

  // reference model state
  logic [DATA_W-1:0]     sram_m [SRAM_WORDS];
  logic [IRQ_W-1:0]      pend_m = '0;
  logic                  kb_valid_m = 1'b0;
  logic [KB_FRAME_W-1:0] kb_frame_m = '0;
  logic [31:0]           lfsr = 32'h5c9f;

  int mismatches = 0;
  int other_errors = 0;
  int watchdog_cycles = 0;

  string       rec_name[$];
  string       rec_op[$];
  logic [31:0] rec_a[$];
  logic [31:0] rec_b[$];
  logic [31:0] rec_c[$];

  always #5 clk = ~clk;

  periph_top #(
    .SRAM_WORDS (SRAM_WORDS),
    .IDLE_LIMIT (IDLE_LIMIT)
  ) dut_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .key_clk   (key_clk),
    .key_data  (key_data),
    .timer_irq (timer_irq),
    .uart_irq  (uart_irq),
    .irq       (irq)
  );

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Mismatch test=%s expected=%h actual=%h", name, exp, act);
    mismatches++;
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      w = {w[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    case (addr[31:16])
      REGION_SRAM: return sram_m[(addr >> 2) % SRAM_WORDS];
      REGION_IRQ:  return 32'(pend_m);
      REGION_KEYB: return 32'({kb_valid_m, kb_frame_m});
      default:     return '0;
    endcase
  endfunction

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    @(negedge clk);
    bus_req.address    = addr;
    bus_req.writedata  = data;
    bus_req.byteenable = be;
    bus_req.write      = 1'b1;
    @(negedge clk);
    bus_req.write = 1'b0;
    if (addr[31:16] == REGION_SRAM) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) sram_m[(addr >> 2) % SRAM_WORDS][8*i +: 8] = data[8*i +: 8];
      end
    end
    if (addr[31:16] == REGION_IRQ && addr[15:2] == 0) pend_m &= ~data[IRQ_W-1:0];
  endtask

  // holds read until waitrequest drops and counts the wait cycles
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output int waits);
    waits = 0;
    @(negedge clk);
    bus_req.address = addr;
    bus_req.read    = 1'b1;
    @(posedge clk);
    while (bus_rsp.waitrequest !== 1'b0 && waits < MAX_WAITS) begin
      waits++;
      @(posedge clk);
    end
    data = bus_rsp.readdata;
    @(negedge clk);
    bus_req.read = 1'b0;
    if (addr[31:16] == REGION_KEYB) kb_valid_m = 1'b0;
  endtask

  // data settles while key_clk is low and is sampled on the rise
  task automatic ps2_bit(input logic b);
    @(negedge clk);
    key_data = b;
    key_clk  = 1'b0;
    repeat (KB_HALF) @(negedge clk);
    key_clk = 1'b1;
    repeat (KB_HALF - 1) @(negedge clk);
  endtask

  task automatic ps2_send(input logic [7:0] data, input int nbits);
    logic [10:0] bits;
    bits = {1'b1, ~^data, data, 1'b0};   // stop, odd parity, data, start
    for (int i = 0; i < nbits; i++) begin
      ps2_bit(bits[i]);
      if (i < KB_FRAME_W) kb_frame_m[i] = bits[i];
    end
    key_data = 1'b1;
    if (nbits == 11) begin
      kb_valid_m       = 1'b1;
      pend_m[IRQ_KEYB] = 1'b1;
    end
  endtask

  task automatic irq_pulse(input logic [31:0] src, input logic [31:0] cycles);
    @(negedge clk);
    if (src == 0) timer_irq = 1'b1;
    else uart_irq = 1'b1;
    repeat (cycles) @(negedge clk);
    timer_irq = 1'b0;
    uart_irq  = 1'b0;
    repeat (3) @(negedge clk);   // two-cycle latency plus margin
    pend_m[(src == 0) ? IRQ_TIMER : IRQ_UART] = 1'b1;
  endtask

  function automatic int record_cycles(input string op, input logic [31:0] a,
                                       input logic [31:0] b);
    if (op == "fill") return 2 * b;
    else if (op == "kb") return 22 * KB_HALF;
    else if (op == "part") return 2 * KB_HALF * a;
    else if (op == "idle") return a;
    else if (op == "pulse") return b + 4;
    else return 5;
  endfunction

  task automatic load_records(output bit ok);
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    ok = 1'b0;
    fd = $fopen("verification/periph_input.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%s %s %h %h %h", name, op, a, b, c);
      if (n == 5 && name.substr(0, 0) != "#") begin
        rec_name.push_back(name);
        rec_op.push_back(op);
        rec_a.push_back(a);
        rec_b.push_back(b);
        rec_c.push_back(c);
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  initial begin
    bit          ok;
    int          total;
    int          waits;
    int          sva_fails;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [31:0] act;
    reset_n   = 1'b0;
    bus_req   = '0;
    key_clk   = 1'b1;   // ps2 lines idle high
    key_data  = 1'b1;
    timer_irq = 1'b0;
    uart_irq  = 1'b0;
    load_records(ok);
    if (!ok) begin
      $display("error: cannot open verification/periph_input.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      total = 10;
      for (int i = 0; i < rec_op.size(); i++) begin
        total += record_cycles(rec_op[i], rec_a[i], rec_b[i]);
      end
      watchdog_cycles = 2 * total;
      repeat (4) @(negedge clk);
      reset_n = 1'b1;
      @(negedge clk);

      for (int i = 0; i < rec_op.size(); i++) begin
        name = rec_name[i];
        op   = rec_op[i];
        a    = rec_a[i];
        b    = rec_b[i];
        if (op == "wr") begin
          bus_write(a, b, rec_c[i][3:0]);
        end else if (op == "rd" || op == "rdm") begin
          exp = (op == "rd") ? b : model_read(a);
          bus_read(a, act, waits);
          if (waits >= MAX_WAITS) begin
            $display("error: test %s, read of %h never dropped waitrequest", name, a);
            other_errors++;
          end else begin
            if (act !== exp) report_mismatch(name, exp, act);
            if (waits != ((a[31:16] == REGION_SRAM) ? 1 : 0)) begin
              report_mismatch({name, " wait"}, (a[31:16] == REGION_SRAM) ? 1 : 0, waits);
            end
          end
        end else if (op == "fill") begin
          for (int j = 0; j < b; j++) begin
            random_word(act);
            bus_write(a + 4 * j, act, 4'hf);
          end
        end else if (op == "kb") begin
          ps2_send(a[7:0], 11);
        end else if (op == "part") begin
          ps2_send(b[7:0], a);
        end else if (op == "idle") begin
          repeat (a) @(negedge clk);
        end else if (op == "pulse") begin
          irq_pulse(a, b);
        end else if (op == "irqchk") begin
          @(negedge clk);
          if (irq !== a[0]) report_mismatch(name, a[0], irq);
        end else begin
          $display("error: test %s uses unknown operation %s", name, op);
          other_errors++;
        end
      end

      sva_fails = dut_i.periph_top_sva_i.fail_count;
      $display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
               mismatches, other_errors, sva_fails);
      if (mismatches == 0 && other_errors == 0 && sva_fails == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("error: watchdog expired after %0d cycles, stimulus never finished",
             watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/periph_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_top_sva
  import periph_pkg::*;
(
  input wire             clk,
  input wire             reset_n,
  input wire bus_req_t   bus_req,
  input wire bus_rsp_t   bus_rsp,
  input wire             irq,
  input wire [IRQ_W-1:0] irq_status
);

  logic sram_rd;
  int   fail_count = 0;

  assign sram_rd = bus_req.read && (bus_req.address[31:16] == REGION_SRAM);

  wait_only_sram: assert property (@(posedge clk) disable iff (!reset_n)
    bus_rsp.waitrequest |-> sram_rd)
    else begin
      $error("waitrequest high outside an SRAM read");
      fail_count++;
    end

  // a single wait state per read
  wait_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    bus_rsp.waitrequest |=> !bus_rsp.waitrequest)
    else begin
      $error("SRAM waitrequest held longer than one cycle");
      fail_count++;
    end

  irq_is_or: assert property (@(posedge clk) disable iff (!reset_n)
    irq == (|irq_status))
    else begin
      $error("irq differs from the OR of the pending bits");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk)
    $rose(reset_n) |-> (!bus_rsp.waitrequest && !irq))
    else begin
      $error("waitrequest or irq high right after reset release");
      fail_count++;
    end

endmodule

bind periph_top periph_top_sva periph_top_sva_i (
  .clk        (clk),
  .reset_n    (reset_n),
  .bus_req    (bus_req),
  .bus_rsp    (bus_rsp),
  .irq        (irq),
  .irq_status (irq_status)
);

`default_nettype wire

/* rtl/periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_top
  import periph_pkg::*;
#(
  parameter int SRAM_WORDS = 512,
  parameter int IDLE_LIMIT = 65535
) (
  input  wire           clk,
  input  wire           reset_n,
  input  wire bus_req_t bus_req,
  output bus_rsp_t      bus_rsp,
  input  wire           key_clk,
  input  wire           key_data,
  input  wire           timer_irq,
  input  wire           uart_irq,
  output logic          irq
);

  bus_rsp_t              sram_rsp;
  logic [KB_FRAME_W:0]   kb_word;
  logic                  kb_frame_done;
  logic [IRQ_W-1:0]      irq_src;
  logic [IRQ_W-1:0]      irq_status;

  // source order follows the pending register layout
  assign irq_src[IRQ_TIMER] = timer_irq;
  assign irq_src[IRQ_UART]  = uart_irq;
  assign irq_src[IRQ_KEYB]  = kb_frame_done;

  sram_bank #(
    .SRAM_WORDS (SRAM_WORDS)
  ) sram_bank_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus_req  (bus_req),
    .sram_rsp (sram_rsp)
  );

  ps2_keyboard_rx #(
    .IDLE_LIMIT (IDLE_LIMIT)
  ) ps2_keyboard_rx_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus_req       (bus_req),
    .key_clk       (key_clk),
    .key_data      (key_data),
    .kb_word       (kb_word),
    .kb_frame_done (kb_frame_done)
  );

  irq_controller irq_controller_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .bus_req    (bus_req),
    .irq_src    (irq_src),
    .irq_status (irq_status),
    .irq        (irq)
  );

  // single response back to the master
  bus_readback bus_readback_i (
    .bus_req    (bus_req),
    .sram_rsp   (sram_rsp),
    .kb_word    (kb_word),
    .irq_status (irq_status),
    .bus_rsp    (bus_rsp)
  );

endmodule

`default_nettype wire

/* rtl/bus_readback.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_readback
  import periph_pkg::*;
(
  input  wire bus_req_t        bus_req,
  input  wire bus_rsp_t        sram_rsp,
  input  wire [KB_FRAME_W:0]   kb_word,
  input  wire [IRQ_W-1:0]      irq_status,
  output bus_rsp_t             bus_rsp
);

  region_e region;

  // region decode on the upper half of the address
  always_comb begin
    case (bus_req.address[31:16])
      REGION_SRAM: region = region_sram;
      REGION_IRQ:  region = region_irq;
      REGION_KEYB: region = region_keyb;
      default:     region = region_none;
    endcase
  end

  always_comb begin
    bus_rsp.readdata    = '0;
    bus_rsp.waitrequest = 1'b0;   // only the SRAM ever stalls
    case (region)
      region_sram: begin
        bus_rsp.readdata    = sram_rsp.readdata;
        bus_rsp.waitrequest = sram_rsp.waitrequest;
      end
      region_irq: begin
        bus_rsp.readdata = {{(DATA_W-IRQ_W){1'b0}}, irq_status};
      end
      region_keyb: begin
        // valid flag sits above the frame
        bus_rsp.readdata = {{(DATA_W-KB_FRAME_W-1){1'b0}}, kb_word};
      end
      default: begin
        bus_rsp.readdata    = '0;   // unmapped reads as zero
        bus_rsp.waitrequest = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/irq_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_controller
  import periph_pkg::*;
(
  input  wire               clk,
  input  wire               reset_n,
  input  wire bus_req_t     bus_req,
  input  wire [IRQ_W-1:0]   irq_src,
  output logic [IRQ_W-1:0]  irq_status,
  output logic              irq
);

  logic [IRQ_W-1:0] src_q;      // sources registered once
  logic [IRQ_W-1:0] src_d;
  logic [IRQ_W-1:0] src_rise;
  logic [IRQ_W-1:0] pending;
  logic [IRQ_W-1:0] clr_mask;
  logic             clr_wr;

  assign src_rise = src_q & ~src_d;

  // write-one-to-clear at word offset 0
  assign clr_wr   = (bus_req.address[31:16] == REGION_IRQ) && bus_req.write
                    && (bus_req.address[15:2] == '0);
  assign clr_mask = clr_wr ? bus_req.writedata[IRQ_W-1:0] : '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      src_q   <= '0;
      src_d   <= '0;
      pending <= '0;
    end else begin
      src_q   <= irq_src;
      src_d   <= src_q;
      pending <= (pending & ~clr_mask) | src_rise;   // new edge beats a clear
    end
  end

  assign irq_status = pending;
  assign irq        = |pending;

endmodule

`default_nettype wire

/* rtl/ps2_keyboard_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx
  import periph_pkg::*;
#(
  parameter int IDLE_LIMIT = 65535
) (
  input  wire                  clk,
  input  wire                  reset_n,
  input  wire bus_req_t        bus_req,
  input  wire                  key_clk,
  input  wire                  key_data,
  output logic [KB_FRAME_W:0]  kb_word,
  output logic                 kb_frame_done
);

  localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);
  localparam int POS_W  = $clog2(KB_FRAME_W + 1);

  logic [1:0]            clk_sync;   // key_clk comes from off chip
  logic                  clk_prev;
  logic                  clk_rise;
  logic [IDLE_W-1:0]     idle_cnt;
  logic                  idle;
  logic [POS_W-1:0]      bitpos;
  logic                  last_bit;
  logic [KB_FRAME_W-1:0] frame_q;
  logic                  valid_q;
  logic                  done_q;
  logic                  kb_rd;

  assign clk_rise = clk_sync[1] && !clk_prev;
  assign idle     = (idle_cnt == IDLE_W'(IDLE_LIMIT));
  assign last_bit = (bitpos == POS_W'(KB_FRAME_W));   // stop bit edge
  assign kb_rd    = (bus_req.address[31:16] == REGION_KEYB) && bus_req.read;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      clk_sync <= 2'b11;   // line idles high
      clk_prev <= 1'b1;
      idle_cnt <= '0;
      bitpos   <= '0;
      valid_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      clk_sync <= {clk_sync[0], key_clk};
      clk_prev <= clk_sync[1];
      done_q   <= 1'b0;

      if (!idle) begin
        idle_cnt <= idle_cnt + 1'b1;   // saturates at the limit
      end

      // valid clears after the bus has seen it
      if (kb_rd) begin
        valid_q <= 1'b0;
      end

      if (clk_rise) begin
        idle_cnt <= '0;
        if (idle) begin
          bitpos <= POS_W'(1);   // stale partial frame dropped
        end else if (last_bit) begin
          bitpos  <= '0;
          valid_q <= 1'b1;
          done_q  <= 1'b1;
        end else begin
          bitpos <= bitpos + 1'b1;
        end
      end
    end
  end

  // frame bits with the start bit at bit 0
  always_ff @(posedge clk) begin
    if (clk_rise) begin
      if (idle) begin
        frame_q[0] <= key_data;
      end else if (!last_bit) begin
        frame_q[bitpos] <= key_data;
      end
    end
  end

  assign kb_word       = {valid_q, frame_q};
  assign kb_frame_done = done_q;

endmodule

`default_nettype wire

/* rtl/sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_bank
  import periph_pkg::*;
#(
  parameter int SRAM_WORDS = 512
) (
  input  wire           clk,
  input  wire           reset_n,
  input  wire bus_req_t bus_req,
  output bus_rsp_t      sram_rsp
);

  localparam int IDX_W  = $clog2(SRAM_WORDS);
  localparam int LANE_W = DATA_W / BE_W;

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [DATA_W-1:0] rd_q;      // registered array output
  logic              read_ack;
  logic              sel;
  logic              rd_req;
  logic              wr_en;
  logic [IDX_W-1:0]  idx;

  assign sel    = (bus_req.address[31:16] == REGION_SRAM);
  assign rd_req = sel && bus_req.read;
  assign wr_en  = sel && bus_req.write;
  assign idx    = bus_req.address[IDX_W+1:2];   // word index without the byte offset

  // byte lanes written only where enabled
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < BE_W; i++) begin
        if (bus_req.byteenable[i]) begin
          mem[idx][LANE_W*i +: LANE_W] <= bus_req.writedata[LANE_W*i +: LANE_W];
        end
      end
    end
    rd_q <= mem[idx];
  end

  // ack gives one wait cycle per read and drops with the read strobe
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else begin
      if (rd_req && !read_ack) begin
        read_ack <= 1'b1;
      end
      if (!rd_req && read_ack) begin
        read_ack <= 1'b0;
      end
    end
  end

  assign sram_rsp.readdata    = rd_q;
  assign sram_rsp.waitrequest = rd_req && !read_ack;

endmodule

`default_nettype wire

/* rtl/periph_pkg.sv */
`default_nettype none

package periph_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;

  // region codes at address[31:16]
  localparam logic [15:0] REGION_SRAM = 16'h0200;
  localparam logic [15:0] REGION_IRQ  = 16'h0202;
  localparam logic [15:0] REGION_KEYB = 16'h0207;

  // interrupt sources and their bit positions
  localparam int IRQ_W     = 3;
  localparam int IRQ_TIMER = 0;
  localparam int IRQ_UART  = 1;
  localparam int IRQ_KEYB  = 2;

  // start + 8 data + parity without the stop bit
  localparam int KB_FRAME_W = 10;

  // one bus cycle from the master
  typedef struct packed {
    logic [ADDR_W-1:0] address;
    logic              read;
    logic              write;
    logic [DATA_W-1:0] writedata;
    logic [BE_W-1:0]   byteenable;
  } bus_req_t;

  // slave answer
  typedef struct packed {
    logic [DATA_W-1:0] readdata;
    logic              waitrequest;
  } bus_rsp_t;

  typedef enum logic [15:0] {
    region_sram = REGION_SRAM,
    region_irq  = REGION_IRQ,
    region_keyb = REGION_KEYB,
    region_none = 16'hFFFF   // anything not mapped
  } region_e;

endpackage

`default_nettype wire
